// ==== include/exu_params.svh ====
// Execute cluster sizing macros
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// ##########################################################
// Datapath and register file dimensions
// ##########################################################

// Width of every register and ALU operand.
`define EXU_XLEN 32

// Architectural registers, x0 included.
`define EXU_REG_COUNT 32

// Bits needed to name one register.
`define EXU_REG_AW 5

`endif

// ==== hdl/exu_pkg.sv ====
// Execute cluster types
package exu_pkg;

    // ##########################################################
    // ALU operation codes
    // ##########################################################
    typedef enum logic [3:0] {
        ADD    = 4'd0,   // opa + opb.
        SUB    = 4'd1,   // opa - opb.
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,   // Shift amount is opb[4:0].
        SRL    = 4'd6,
        SRA    = 4'd7,   // Sign bit fills from the left.
        SLT    = 4'd8,   // Signed compare, 1 or 0.
        SLTU   = 4'd9,   // Unsigned compare, 1 or 0.
        PASS_B = 4'd10   // Used by lui style ops.
    } alu_op_e;

    // ##########################################################
    // Operand source selects
    // ##########################################################
    typedef enum logic {
        SRC_A_RS1 = 1'b0,  // Resolved rs1 value.
        SRC_A_PC  = 1'b1   // Instruction address.
    } src_a_e;

    // Encoding 2'b11 is not defined.
    typedef enum logic [1:0] {
        SRC_B_RS2  = 2'b00,  // Resolved rs2 value.
        SRC_B_IMM  = 2'b01,  // Decoded immediate.
        SRC_B_FOUR = 2'b10   // Link offset for jal and jalr.
    } src_b_e;

endpackage

// ==== hdl/exu_op_if.sv ====
// Resolved operation channel
`timescale 1ns/10ps
`include "exu_params.svh"

interface exu_op_if
    import exu_pkg::*;
();

    logic                   valid;    // Single-cycle strobe, no back-pressure.
    alu_op_e                alu_op;   // Operation to run in the ALU stage.
    logic [`EXU_REG_AW-1:0] rd;       // Destination register.
    logic [`EXU_XLEN-1:0]   opa;      // First ALU input, already selected.
    logic [`EXU_XLEN-1:0]   opb;      // Second ALU input, already selected.

    // Operand stage side.
    modport producer (
        output valid,
        output alu_op,
        output rd,
        output opa,
        output opb
    );

    // ALU stage side.
    modport consumer (
        input valid,
        input alu_op,
        input rd,
        input opa,
        input opb
    );

endinterface

// ==== hdl/exu_regfile.sv ====
// Integer register file
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`EXU_REG_AW-1:0] rs1_addr,
    input  logic [`EXU_REG_AW-1:0] rs2_addr,
    output logic [`EXU_XLEN-1:0]   rs1_data,
    output logic [`EXU_XLEN-1:0]   rs2_data,
    input  logic                   wr_en,
    input  logic [`EXU_REG_AW-1:0] wr_addr,
    input  logic [`EXU_XLEN-1:0]   wr_data
);

    logic [`EXU_XLEN-1:0] regs [`EXU_REG_COUNT];

    // ##########################################################
    // Write port
    // ##########################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin  // x0 is never written.
            regs[wr_addr] <= wr_data;
        end
    end

    // ##########################################################
    // Read ports
    // ##########################################################
    // No write-through here; the writeback stage forwards the
    // value that is being written in the same cycle.
    assign rs1_data = regs[rs1_addr];  // x0 holds its reset value of zero.
    assign rs2_data = regs[rs2_addr];

    // Register 0 reads zero on both ports.
    property p_x0_reads_zero;
        @(posedge clk) disable iff (!rst_n)
            ((rs1_addr != '0) || (rs1_data == '0)) &&
            ((rs2_addr != '0) || (rs2_data == '0));
    endproperty

    a_x0_reads_zero: assert property (p_x0_reads_zero)
        else $error("regfile: x0 read back nonzero");

endmodule

// ==== hdl/exu_operand_sel.sv ====
// Operand forwarding and select
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_operand_sel
    import exu_pkg::*;
(
    input  logic                   issue_valid,
    input  logic [3:0]             issue_alu_op,
    input  logic                   issue_src_a,
    input  logic [1:0]             issue_src_b,
    input  logic [`EXU_REG_AW-1:0] issue_rd,
    input  logic [`EXU_XLEN-1:0]   issue_pc,
    input  logic [`EXU_XLEN-1:0]   issue_imm,
    input  logic [`EXU_REG_AW-1:0] rs1_addr,
    input  logic [`EXU_REG_AW-1:0] rs2_addr,
    input  logic [`EXU_XLEN-1:0]   rf_rs1_data,
    input  logic [`EXU_XLEN-1:0]   rf_rs2_data,
    input  logic                   ex_valid,
    input  logic [`EXU_REG_AW-1:0] ex_rd,
    input  logic [`EXU_XLEN-1:0]   ex_data,
    input  logic                   wb_valid,
    input  logic [`EXU_REG_AW-1:0] wb_rd,
    input  logic [`EXU_XLEN-1:0]   wb_data,
    exu_op_if.producer             op
);

    logic [`EXU_XLEN-1:0] rs1_val;  // rs1 after forwarding.
    logic [`EXU_XLEN-1:0] rs2_val;  // rs2 after forwarding.

    // ##########################################################
    // Hazard detection
    // ##########################################################
    // The ALU stage holds the newer result, so it wins.
    function automatic logic [`EXU_XLEN-1:0] fwd_pick(
        input logic [`EXU_REG_AW-1:0] src,
        input logic [`EXU_XLEN-1:0]   rf_val,
        input logic                   e_valid,
        input logic [`EXU_REG_AW-1:0] e_rd,
        input logic [`EXU_XLEN-1:0]   e_data,
        input logic                   w_valid,
        input logic [`EXU_REG_AW-1:0] w_rd,
        input logic [`EXU_XLEN-1:0]   w_data
    );
        logic hit_ex;
        logic hit_wb;
        hit_ex = e_valid && (e_rd == src) && (e_rd != '0);
        hit_wb = w_valid && (w_rd == src) && (w_rd != '0);
        if (hit_ex) begin
            return e_data;
        end else if (hit_wb) begin
            return w_data;
        end
        return rf_val;  // Regfile already returns zero for x0.
    endfunction

    assign rs1_val = fwd_pick(rs1_addr, rf_rs1_data, ex_valid, ex_rd, ex_data,
                              wb_valid, wb_rd, wb_data);
    assign rs2_val = fwd_pick(rs2_addr, rf_rs2_data, ex_valid, ex_rd, ex_data,
                              wb_valid, wb_rd, wb_data);

    // ##########################################################
    // ALU input select
    // ##########################################################
    assign op.valid  = issue_valid;
    assign op.alu_op = alu_op_e'(issue_alu_op);
    assign op.rd     = issue_rd;
    assign op.opa    = (issue_src_a == SRC_A_PC) ? issue_pc : rs1_val;

    always_comb begin
        case (issue_src_b)
            SRC_B_RS2:  op.opb = rs2_val;
            SRC_B_IMM:  op.opb = issue_imm;
            SRC_B_FOUR: op.opb = `EXU_XLEN'd4;  // pc + 4 link value.
            default:    op.opb = '0;
        endcase
    end

    // Decode must never issue the spare src_b encoding.
    always_comb begin
        if (issue_valid) begin
            a_src_b_legal: assert (issue_src_b inside {SRC_B_RS2, SRC_B_IMM, SRC_B_FOUR})
                else $error("operand_sel: undefined src_b encoding %b", issue_src_b);
        end
    end

endmodule

// ==== hdl/exu_alu.sv ====
// Execute stage ALU
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_alu
    import exu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    exu_op_if.consumer             op,
    output logic                   ex_valid,
    output logic [`EXU_REG_AW-1:0] ex_rd,
    output logic [`EXU_XLEN-1:0]   ex_data
);

    logic                   valid_q;
    alu_op_e                alu_op_q;
    logic [`EXU_REG_AW-1:0] rd_q;
    logic [`EXU_XLEN-1:0]   opa_q;
    logic [`EXU_XLEN-1:0]   opb_q;
    logic [4:0]             shamt;     // Low five bits of opb.

    // ##########################################################
    // Issue register
    // ##########################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= op.valid;
        end
    end

    // Payload only moves on a valid issue.
    always_ff @(posedge clk) begin
        if (op.valid) begin
            alu_op_q <= op.alu_op;
            rd_q     <= op.rd;
            opa_q    <= op.opa;
            opb_q    <= op.opb;
        end
    end

    // ##########################################################
    // Arithmetic and logic
    // ##########################################################
    assign shamt = opb_q[4:0];

    always_comb begin
        case (alu_op_q)
            ADD:     ex_data = opa_q + opb_q;
            SUB:     ex_data = opa_q - opb_q;
            AND:     ex_data = opa_q & opb_q;
            OR:      ex_data = opa_q | opb_q;
            XOR:     ex_data = opa_q ^ opb_q;
            SLL:     ex_data = opa_q << shamt;
            SRL:     ex_data = opa_q >> shamt;
            SRA:     ex_data = $unsigned($signed(opa_q) >>> shamt);
            SLT:     ex_data = {{(`EXU_XLEN-1){1'b0}}, $signed(opa_q) < $signed(opb_q)};
            SLTU:    ex_data = {{(`EXU_XLEN-1){1'b0}}, opa_q < opb_q};
            PASS_B:  ex_data = opb_q;
            default: ex_data = '0;  // Unused opcodes.
        endcase
    end

    assign ex_valid = valid_q;
    assign ex_rd    = rd_q;

    // One issue gives exactly one result a cycle later.
    property p_ex_follows_issue;
        @(posedge clk) disable iff (!rst_n)
            $past(rst_n) |-> (ex_valid == $past(op.valid));
    endproperty

    a_ex_follows_issue: assert property (p_ex_follows_issue)
        else $error("alu: ex_valid does not follow issue by one cycle");

endmodule

// ==== hdl/exu_wb_stage.sv ====
// Writeback stage register
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_wb_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_valid,
    input  logic [`EXU_REG_AW-1:0] ex_rd,
    input  logic [`EXU_XLEN-1:0]   ex_data,
    output logic                   wb_valid,
    output logic [`EXU_REG_AW-1:0] wb_rd,
    output logic [`EXU_XLEN-1:0]   wb_data
);

    // ##########################################################
    // Result register
    // ##########################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid;  // Also the regfile write enable.
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd   <= ex_rd;
            wb_data <= ex_data;
        end
    end

    // wb_valid trails ex_valid by one cycle.
    property p_wb_follows_ex;
        @(posedge clk) disable iff (!rst_n)
            $past(rst_n) |-> (wb_valid == $past(ex_valid));
    endproperty

    a_wb_follows_ex: assert property (p_wb_follows_ex)
        else $error("wb_stage: wb_valid does not follow ex_valid");

endmodule

// ==== hdl/exu_top.sv ====
// Execute cluster top level
`timescale 1ns/10ps
`include "exu_params.svh"

module exu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue_valid,
    input  logic [3:0]             issue_alu_op,
    input  logic                   issue_src_a,
    input  logic [1:0]             issue_src_b,
    input  logic [`EXU_REG_AW-1:0] issue_rs1,
    input  logic [`EXU_REG_AW-1:0] issue_rs2,
    input  logic [`EXU_REG_AW-1:0] issue_rd,
    input  logic [`EXU_XLEN-1:0]   issue_pc,
    input  logic [`EXU_XLEN-1:0]   issue_imm,
    output logic                   res_valid,
    output logic [`EXU_REG_AW-1:0] res_rd,
    output logic [`EXU_XLEN-1:0]   res_data
);

    logic [`EXU_XLEN-1:0]   rf_rs1_data;
    logic [`EXU_XLEN-1:0]   rf_rs2_data;
    logic                   ex_valid;    // ALU stage, newer forward source.
    logic [`EXU_REG_AW-1:0] ex_rd;
    logic [`EXU_XLEN-1:0]   ex_data;
    logic                   wb_valid;    // Writeback stage, older forward source.
    logic [`EXU_REG_AW-1:0] wb_rd;
    logic [`EXU_XLEN-1:0]   wb_data;

    exu_op_if op_if ();

    // ##########################################################
    // Issue cycle
    // ##########################################################
    exu_regfile exu_regfile_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (issue_rs1),
        .rs2_addr (issue_rs2),
        .rs1_data (rf_rs1_data),
        .rs2_data (rf_rs2_data),
        .wr_en    (wb_valid),
        .wr_addr  (wb_rd),
        .wr_data  (wb_data)
    );

    exu_operand_sel exu_operand_sel_inst (
        .issue_valid  (issue_valid),
        .issue_alu_op (issue_alu_op),
        .issue_src_a  (issue_src_a),
        .issue_src_b  (issue_src_b),
        .issue_rd     (issue_rd),
        .issue_pc     (issue_pc),
        .issue_imm    (issue_imm),
        .rs1_addr     (issue_rs1),
        .rs2_addr     (issue_rs2),
        .rf_rs1_data  (rf_rs1_data),
        .rf_rs2_data  (rf_rs2_data),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_data      (ex_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .op           (op_if.producer)
    );

    // ##########################################################
    // Execute and writeback
    // ##########################################################
    exu_alu exu_alu_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (op_if.consumer),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .ex_data  (ex_data)
    );

    exu_wb_stage exu_wb_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_valid (ex_valid),
        .ex_rd    (ex_rd),
        .ex_data  (ex_data),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    assign res_valid = wb_valid;
    assign res_rd    = wb_rd;
    assign res_data  = wb_data;

endmodule

// ==== verification/tb_exu_top.sv ====
// Execute cluster testbench
`timescale 1ns/10ps
`include "exu_params.svh"

module tb_exu_top;

    localparam int NUM_VECS     = 34;                  // Lines in the vector file.
    localparam int FIELDS       = 9;                   // Words per vector line.
    localparam int RESET_CYCLES = 8;
    localparam int RES_LATENCY  = 2;                   // Issue cycle to res_valid cycle.
    localparam int CYCLE_LIMIT  = NUM_VECS + RESET_CYCLES + 20;
    localparam logic [3:0] IDLE_OP = 4'hf;             // Opcode column of a gap line.

    logic                   clk;
    logic                   rst_n;
    logic                   issue_valid;
    logic [3:0]             issue_alu_op;
    logic                   issue_src_a;
    logic [1:0]             issue_src_b;
    logic [`EXU_REG_AW-1:0] issue_rs1;
    logic [`EXU_REG_AW-1:0] issue_rs2;
    logic [`EXU_REG_AW-1:0] issue_rd;
    logic [`EXU_XLEN-1:0]   issue_pc;
    logic [`EXU_XLEN-1:0]   issue_imm;
    logic                   res_valid;
    logic [`EXU_REG_AW-1:0] res_rd;
    logic [`EXU_XLEN-1:0]   res_data;

    logic [31:0]            vec_mem [NUM_VECS*FIELDS];
    logic [`EXU_REG_AW-1:0] exp_rd_q [$];              // Results still in flight.
    logic [`EXU_XLEN-1:0]   exp_data_q [$];
    int                     exp_line_q [$];
    int                     exp_cycle_q [$];           // Cycle the result is due in.
    int cycle_cnt    = 0;
    int issued_cnt   = 0;
    int tests_done   = 0;
    int tests_failed = 0;
    int error_cnt    = 0;

    exu_top exu_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_alu_op (issue_alu_op),
        .issue_src_a  (issue_src_a),
        .issue_src_b  (issue_src_b),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .issue_pc     (issue_pc),
        .issue_imm    (issue_imm),
        .res_valid    (res_valid),
        .res_rd       (res_rd),
        .res_data     (res_data)
    );

    always #5 clk = ~clk;

    // ##########################################################
    // Vector loading and issue
    // ##########################################################
    task automatic load_vectors();
        for (int i = 0; i < NUM_VECS*FIELDS; i++) begin
            vec_mem[i] = 32'hbad0_0000 | i;  // Marks words the file never wrote.
        end
        $readmemh("verification/exu_input.txt", vec_mem);
        if (vec_mem[NUM_VECS*FIELDS-1] == (32'hbad0_0000 | (NUM_VECS*FIELDS-1))) begin
            $display("Vector file is missing or holds fewer than %0d lines", NUM_VECS);
            error_cnt++;
        end
    endtask

    task automatic drive_vector(input int line);
        int         base;
        int         issue_cycle;
        logic [3:0] op;
        base        = line * FIELDS;
        op          = vec_mem[base][3:0];
        issue_cycle = cycle_cnt + 1;  // Count of this edge lands after the NBA.
        if (op == IDLE_OP) begin
            issue_valid <= 1'b0;  // Gap cycle.
        end else begin
            issue_valid  <= 1'b1;
            issue_alu_op <= op;
            issue_src_a  <= vec_mem[base+1][0];
            issue_src_b  <= vec_mem[base+2][1:0];
            issue_rs1    <= vec_mem[base+3][`EXU_REG_AW-1:0];
            issue_rs2    <= vec_mem[base+4][`EXU_REG_AW-1:0];
            issue_rd     <= vec_mem[base+5][`EXU_REG_AW-1:0];
            issue_pc     <= vec_mem[base+6];
            issue_imm    <= vec_mem[base+7];
            exp_rd_q.push_back(vec_mem[base+5][`EXU_REG_AW-1:0]);
            exp_data_q.push_back(vec_mem[base+8]);
            exp_line_q.push_back(line);
            exp_cycle_q.push_back(issue_cycle + RES_LATENCY);
            issued_cnt++;
        end
    endtask

    // ##########################################################
    // Result checking
    // ##########################################################
    task automatic check_result();
        logic [`EXU_REG_AW-1:0] want_rd;
        logic [`EXU_XLEN-1:0]   want_data;
        int                     line;
        int                     want_cycle;
        int                     errs_before;
        want_rd     = exp_rd_q.pop_front();
        want_data   = exp_data_q.pop_front();
        line        = exp_line_q.pop_front();
        want_cycle  = exp_cycle_q.pop_front();
        errs_before = error_cnt;
        if (cycle_cnt != want_cycle) begin
            $display("[ERROR] %0d ns: res_valid expected in cycle %0d, actual cycle %0d",
                     $time, want_cycle, cycle_cnt);
            error_cnt++;
        end
        if (res_rd !== want_rd) begin
            $display("[ERROR] %0d ns: res_rd expected %0d, actual %0d", $time, want_rd, res_rd);
            error_cnt++;
        end
        if (res_data !== want_data) begin
            $display("[ERROR] %0d ns: res_data expected %h, actual %h",
                     $time, want_data, res_data);
            error_cnt++;
        end
        tests_done++;
        if (error_cnt != errs_before) begin
            tests_failed++;
            $display("test %0d (line %0d, x%0d): failed", tests_done, line, want_rd);
        end else begin
            $display("test %0d (line %0d, x%0d): passed", tests_done, line, want_rd);
        end
    endtask

    // Outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (rst_n && res_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("Result for x%0d appeared at %0d ns with no issue pending",
                         res_rd, $time);
                error_cnt++;
            end else begin
                check_result();
            end
        end
    end

    task automatic report_summary();
        if (exp_rd_q.size() != 0) begin
            $display("%0d issued results never appeared", exp_rd_q.size());
            error_cnt++;
        end
        $display("Summary: %0d issued, %0d tests, %0d passed, %0d failed, %0d errors",
                 issued_cnt, tests_done, tests_done - tests_failed, tests_failed, error_cnt);
    endtask

    // Watchdog.
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     CYCLE_LIMIT, exp_rd_q.size());
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ##########################################################
    // Main sequence
    // ##########################################################
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        issue_valid  = 1'b0;
        issue_alu_op = '0;
        issue_src_a  = 1'b0;
        issue_src_b  = '0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_rd     = '0;
        issue_pc     = '0;
        issue_imm    = '0;
        load_vectors();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        for (int line = 0; line < NUM_VECS; line++) begin
            @(posedge clk);
            drive_vector(line);
        end
        @(posedge clk);
        issue_valid <= 1'b0;
        while (exp_rd_q.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);  // Catch stray res_valid pulses.
        report_summary();
        if (error_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verification/exu_input.txt ====
// op src_a src_b rs1 rs2 rd pc imm expected, all hex
// An op of f marks an idle cycle with no issue
0 0 1 00 00 01 00000000 00000005 00000005
0 0 1 00 00 02 00000000 fffffff0 fffffff0
0 0 1 00 00 03 00000000 12345678 12345678
0 0 1 00 00 04 00000000 0000000f 0000000f
f 0 0 00 00 00 00000000 00000000 00000000
f 0 0 00 00 00 00000000 00000000 00000000
0 0 0 01 02 05 00000000 00000000 fffffff5
1 0 0 05 01 06 00000000 00000000 fffffff0
0 0 0 06 03 07 00000000 00000000 12345668
4 0 0 03 04 08 00000000 00000000 12345677
f 0 0 00 00 00 00000000 00000000 00000000
0 0 0 08 01 09 00000000 00000000 1234567c
0 0 1 00 00 0a 00000000 00000100 00000100
0 0 1 00 00 0a 00000000 00000200 00000200
3 0 0 0a 00 0b 00000000 00000000 00000200
2 0 0 03 0b 0c 00000000 00000000 00000200
0 1 2 00 00 0d 00001000 00000000 00001004
0 1 1 00 00 0e 00002000 fffffffc 00001ffc
a 0 1 00 00 0f 00000000 abcde000 abcde000
0 0 1 00 00 00 00000000 00000123 00000123
0 0 1 00 00 10 00000000 00000007 00000007
f 0 0 00 00 00 00000000 00000000 00000000
0 0 0 00 00 11 00000000 00000000 00000000
5 0 1 03 00 12 00000000 00000004 23456780
6 0 1 02 00 13 00000000 00000004 0fffffff
7 0 1 02 00 14 00000000 00000004 ffffffff
7 0 1 03 00 15 00000000 00000024 01234567
8 0 0 02 01 16 00000000 00000000 00000001
9 0 0 02 01 17 00000000 00000000 00000000
8 0 0 01 02 18 00000000 00000000 00000000
9 0 0 01 02 19 00000000 00000000 00000001
2 0 1 02 00 1a 00000000 000000ff 000000f0
1 0 0 01 04 1b 00000000 00000000 fffffff6
f 0 0 00 00 00 00000000 00000000 00000000

// ==== filelist.f ====
+incdir+include
hdl/exu_pkg.sv
hdl/exu_op_if.sv
hdl/exu_regfile.sv
hdl/exu_operand_sel.sv
hdl/exu_alu.sv
hdl/exu_wb_stage.sv
hdl/exu_top.sv
verification/tb_exu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute cluster testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_exu_top \
    -o sim_exu > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_exu > sim.log 2>&1
cat sim.log

grep -q "FAIL: see errors above" sim.log && echo "Simulation failed" && exit 1
grep -q "PASS: all tests" sim.log || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation passed"
exit 0
